//--- flist.f
terminal_pkg.sv
key_decoder.sv
packet_sender.sv
packet_receiver.sv
message_store.sv
hex_display.sv
cipher_terminal.sv
tb_cipher_terminal.sv

//--- Makefile
# Verilator build and run for the keyboard message terminal testbench

VERILATOR ?= verilator
TOP       ?= tb_cipher_terminal
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter-out +%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -o $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qx "TEST OK" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- tb_cipher_terminal.sv
// ##########################################################################
// Testbench for the keyboard message terminal
//   clock, reset, random key and link stimulus from a fixed seed
//   link partner models, reference model, checks and watchdog
// ##########################################################################
`timescale 1ns/1ps

module tb_cipher_terminal
	import terminal_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_SENDS  = 8;                   // Random key rounds ending in Enter
	localparam int NUM_RX     = 40;                  // More than the buffer holds
	localparam int WORST_TXN  = SEND_HOLDOFF + 64;   // Keys, slow partner, hold-off
	localparam int LIMIT_NS   = ((NUM_SENDS + 8 + NUM_RX) * WORST_TXN + 200) * CLK_PERIOD;

	logic       scan_ready;
	logic       rst_n;
	byte_t      scan_code;
	logic       scan_valid;
	logic       tx_rdy;
	byte_t      tx_data;
	logic       tx_ack;
	logic       rx_rdy;
	byte_t      rx_data;
	logic       rx_ack;
	logic [3:0] word_sel;
	logic [6:0] hex0;
	logic [6:0] hex1;
	logic [6:0] hex2;
	logic [6:0] hex3;
	logic       send_ready;
	space_t     space_count;
	count_t     byte_count;

	// Reference model state
	byte_t      model_char;
	space_t     model_space;
	logic       model_break;                         // Next key is a release
	byte_t      rx_model [$];                        // Bytes in send order
	byte_t      hex_codes [16] = '{8'h45, 8'h16, 8'h1E, 8'h26, 8'h25, 8'h2E, 8'h36, 8'h3D,
	                               8'h3E, 8'h46, 8'h1C, 8'h32, 8'h21, 8'h23, 8'h24, 8'h2B};
	logic [6:0] seg_table [16] = '{7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
	                               7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0E};
	integer     seed;
	string      test_name;
	int         test_errors;
	int         errors;
	int         tests_run;
	int         tests_failed;

	cipher_terminal dut_i (.*);

	initial
	begin
		scan_ready = 1'b0;
		forever #(CLK_PERIOD / 2) scan_ready = ~scan_ready;
	end

	initial
	begin
		#(LIMIT_NS);
		$display("watchdog expired after %0d ns, a handshake never completed", LIMIT_NS);
		$display("TEST FAILED");
		$finish;
	end

	function automatic int rand_below(input int n);
		rand_below = int'($unsigned($random(seed)) % n);
	endfunction

	task automatic report_mismatch(input string what, input int expected, input int actual);
		$display("mismatch %s %s: expected %0h actual %0h", test_name, what, expected, actual);
		test_errors++;
	endtask

	task automatic report_failure(input string what);
		$display("failure in %s: %s", test_name, what);
		test_errors++;
	endtask

	task automatic end_test();
		$display("test %s: %s", test_name, (test_errors == 0) ? "passed" : "failed");
		if (test_errors != 0)
			tests_failed++;
		errors += test_errors;
		test_errors = 0;
		tests_run++;
	endtask

	// One key stroke, valid for a single cycle, then the model follows it
	task automatic press_key(input byte_t code);
		int idx;
		@(negedge scan_ready);
		scan_code  = code;
		scan_valid = 1'b1;
		@(negedge scan_ready);
		scan_valid = 1'b0;
		scan_code  = byte_t'(rand_below(256));       // Ignored while not valid
		if (code == SC_BREAK)
			model_break = 1'b1;
		else if (model_break)
			model_break = 1'b0;                      // Release of a key
		else
		begin
			for (idx = 0; idx < 16; idx++)
				if (hex_codes[idx] == code)
					model_char = byte_t'((idx < 10) ? ("0" + idx) : ("A" + idx - 10));
			if (code == SC_SPACE)
				model_space = model_space + 10'd1;
		end
	endtask

	task automatic random_keys(input int n);
		byte_t others [4] = '{8'h15, 8'h1D, 8'h4D, 8'h66};   // Outside the hex table
		repeat (n)
		begin
			case (rand_below(5))
				0, 1: press_key(hex_codes[rand_below(16)]);
				2: press_key(SC_SPACE);
				3: press_key(others[rand_below(4)]);
				default: press_key(SC_BREAK);
			endcase
		end
		if (model_break)
			press_key(hex_codes[rand_below(16)]);    // Clear a pending release
	endtask

	// which 0 watches tx_rdy, 1 watches rx_ack
	task automatic wait_for(input string what, input int which, input logic level,
	                        output int cycles);
		logic seen;
		cycles = 0;
		seen   = 1'b0;
		while (!seen && cycles < 20)
		begin
			@(negedge scan_ready);
			cycles++;
			seen = (((which == 0) ? tx_rdy : rx_ack) == level);
		end
		if (!seen)
			report_failure({what, " never arrived"});
	endtask

	task automatic no_offer(input int n);
		repeat (n)
		begin
			@(negedge scan_ready);
			if (tx_rdy)
				report_failure("unexpected offer on tx_rdy");
		end
	endtask

	// Enter, then acknowledge the offer and time the hold-off
	task automatic send_char(input logic inject);
		int   cycles;
		int   low;
		int   enter_at;
		logic done;
		press_key(SC_ENTER);
		wait_for("tx_rdy rise", 0, 1'b1, cycles);
		if (cycles != 1)
			report_mismatch("offer latency", 1, cycles);
		if (tx_data !== model_char)
			report_mismatch("tx_data", int'(model_char), int'(tx_data));
		repeat (rand_below(4)) @(negedge scan_ready);   // Slow partner
		tx_ack = 1'b1;
		wait_for("tx_rdy fall", 0, 1'b0, cycles);
		if (cycles != 1)
			report_mismatch("release latency", 1, cycles);
		repeat (rand_below(4)) @(negedge scan_ready);
		tx_ack   = 1'b0;
		enter_at = inject ? 2 + rand_below(SEND_HOLDOFF - 12) : -10;
		low      = 0;
		done     = 1'b0;
		while (!done && low <= SEND_HOLDOFF + 4)
		begin
			@(negedge scan_ready);
			if (tx_rdy)
				report_failure("offer during hold-off");
			if (send_ready)
				done = 1'b1;
			else
				low++;
			scan_code  = SC_ENTER;
			scan_valid = (low == enter_at);          // Must be dropped
		end
		scan_valid = 1'b0;
		if (low != SEND_HOLDOFF)
			report_mismatch("hold-off cycles", SEND_HOLDOFF, low);
		no_offer(6);
	endtask

	// Partner side of the incoming link
	task automatic send_byte(input byte_t data);
		int cycles;
		repeat (rand_below(4)) @(negedge scan_ready);
		@(negedge scan_ready);
		rx_data = data;
		rx_rdy  = 1'b1;
		wait_for("rx_ack rise", 1, 1'b1, cycles);
		if (cycles != 1)
			report_mismatch("rx_ack rise latency", 1, cycles);
		repeat (rand_below(3)) @(negedge scan_ready);
		rx_rdy  = 1'b0;
		rx_data = byte_t'(rand_below(256));
		wait_for("rx_ack fall", 1, 1'b0, cycles);
		if (cycles != 1)
			report_mismatch("rx_ack fall latency", 1, cycles);
		rx_model.push_back(data);
	endtask

	// Every word_sel value against the word built from the first 32 bytes
	task automatic check_words();
		logic [15:0] word;
		logic [6:0]  got;
		int          w;
		int          n;
		for (w = 0; w < MSG_WORDS; w++)
		begin
			@(negedge scan_ready);
			word_sel = 4'(w);
			word     = '0;
			if (rx_model.size() > 2 * w + 1)
				word = {rx_model[2 * w + 1], rx_model[2 * w]};
			@(negedge scan_ready);
			for (n = 0; n < 4; n++)
			begin
				got = (n == 0) ? hex0 : (n == 1) ? hex1 : (n == 2) ? hex2 : hex3;
				if (got !== seg_table[word[4 * n +: 4]])
					report_mismatch($sformatf("hex%0d word %0d", n, w),
					                int'(seg_table[word[4 * n +: 4]]), int'(got));
			end
		end
	endtask

	initial
	begin
		seed         = 32'hf593;
		rst_n        = 1'b0;
		scan_code    = '0;
		scan_valid   = 1'b0;
		tx_ack       = 1'b0;
		rx_rdy       = 1'b0;
		rx_data      = '0;
		word_sel     = '0;
		model_char   = '0;
		model_space  = '0;
		model_break  = 1'b0;
		test_errors  = 0;
		errors       = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (4) @(posedge scan_ready);
		@(negedge scan_ready);
		rst_n = 1'b1;

		test_name = "reset";
		if (tx_rdy !== 1'b0 || rx_ack !== 1'b0 || send_ready !== 1'b1)
			report_failure("link outputs not idle after reset");
		if (space_count !== '0)
			report_mismatch("space_count", 0, int'(space_count));
		if (byte_count !== '0)
			report_mismatch("byte_count", 0, int'(byte_count));
		check_words();
		end_test();

		test_name = "char_send";
		repeat (NUM_SENDS)
		begin
			random_keys(2 + rand_below(8));
			send_char(1'b0);
		end
		end_test();

		test_name = "hold_off";
		repeat (3)
		begin
			random_keys(3);
			send_char(1'b1);
		end
		end_test();

		test_name = "break_space";
		press_key(8'h3D);                            // Hex key 7
		send_char(1'b0);
		press_key(SC_BREAK);
		press_key(8'h2B);
		press_key(SC_BREAK);
		press_key(SC_SPACE);
		press_key(SC_BREAK);
		press_key(SC_ENTER);                         // Released Enter sends nothing
		no_offer(4);
		send_char(1'b0);
		random_keys(40);
		if (space_count !== model_space)
			report_mismatch("space_count", int'(model_space), int'(space_count));
		end_test();

		test_name = "receive_display";
		repeat (NUM_RX) send_byte(byte_t'(rand_below(256)));
		@(negedge scan_ready);
		if (byte_count !== count_t'(MSG_BYTES))
			report_mismatch("byte_count", MSG_BYTES, int'(byte_count));
		check_words();
		end_test();

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

endmodule

//--- cipher_terminal.sv
// ########################################################################
// Keyboard message terminal, top level
//   key decoder, link sender and receiver,
//   message buffer and seven-segment display
// ########################################################################
`timescale 1ns/1ps

module cipher_terminal
	import terminal_pkg::*;
(
	input  logic       scan_ready,                   // Clock
	input  logic       rst_n,
	input  byte_t      scan_code,                    // Keyboard side
	input  logic       scan_valid,
	output logic       tx_rdy,                       // Outgoing link
	output byte_t      tx_data,
	input  logic       tx_ack,
	input  logic       rx_rdy,                       // Incoming link
	input  byte_t      rx_data,
	output logic       rx_ack,
	input  logic [3:0] word_sel,
	output logic [6:0] hex0,
	output logic [6:0] hex1,
	output logic [6:0] hex2,
	output logic [6:0] hex3,
	output logic       send_ready,
	output space_t     space_count,
	output count_t     byte_count
);

	byte_t    cur_char;
	logic     send_req;
	logic     byte_valid;
	byte_t    byte_data;
	message_t message;

	key_decoder key_decoder_i
	(
		.scan_ready  (scan_ready),
		.rst_n       (rst_n),
		.scan_code   (scan_code),
		.scan_valid  (scan_valid),
		.cur_char    (cur_char),
		.space_count (space_count),
		.send_req    (send_req)
	);

	packet_sender packet_sender_i
	(
		.scan_ready (scan_ready),
		.rst_n      (rst_n),
		.send_req   (send_req),
		.cur_char   (cur_char),
		.tx_rdy     (tx_rdy),
		.tx_data    (tx_data),
		.tx_ack     (tx_ack),
		.send_ready (send_ready)
	);

	packet_receiver packet_receiver_i
	(
		.scan_ready (scan_ready),
		.rst_n      (rst_n),
		.rx_rdy     (rx_rdy),
		.rx_data    (rx_data),
		.rx_ack     (rx_ack),
		.byte_valid (byte_valid),
		.byte_data  (byte_data)
	);

	message_store message_store_i
	(
		.scan_ready (scan_ready),
		.rst_n      (rst_n),
		.byte_valid (byte_valid),
		.byte_data  (byte_data),
		.message    (message),
		.byte_count (byte_count)
	);

	hex_display hex_display_i
	(
		.message  (message),
		.word_sel (word_sel),
		.hex0     (hex0),
		.hex1     (hex1),
		.hex2     (hex2),
		.hex3     (hex3)
	);

endmodule

//--- hex_display.sv
// ########################################################################
// Seven-segment word display
//   picks one 16-bit word of the message by word_sel
//   and drives four active-low digits, hex0 lowest nibble
// ########################################################################
`timescale 1ns/1ps

module hex_display
	import terminal_pkg::*;
(
	input  message_t                     message,
	input  logic [$clog2(MSG_WORDS)-1:0] word_sel,   // Word 0 to 15
	output logic [6:0]                   hex0,
	output logic [6:0]                   hex1,
	output logic [6:0]                   hex2,
	output logic [6:0]                   hex3
);

	byte_t       lo_byte;
	byte_t       hi_byte;
	logic [15:0] word;

	// Bytes 2*sel and 2*sel+1, higher index in the upper half
	assign lo_byte = message[{word_sel, 1'b0}];
	assign hi_byte = message[{word_sel, 1'b1}];
	assign word    = {hi_byte, lo_byte};

	assign hex0 = seg_pattern(word[3:0]);            // Lowest nibble
	assign hex1 = seg_pattern(word[7:4]);
	assign hex2 = seg_pattern(word[11:8]);
	assign hex3 = seg_pattern(word[15:12]);          // Highest nibble

endmodule

//--- message_store.sv
// ########################################################################
// Message buffer
//   32 received bytes stored in arrival order,
//   saturating byte count, extra bytes discarded
// ########################################################################
`timescale 1ns/1ps

module message_store
	import terminal_pkg::*;
(
	input  logic     scan_ready,
	input  logic     rst_n,
	input  logic     byte_valid,                     // From receiver
	input  byte_t    byte_data,
	output message_t message,                        // Byte 0 at the bottom
	output count_t   byte_count
);

	logic            full;
	logic [IDX_W-1:0] wr_idx;

	assign full   = (byte_count == count_t'(MSG_BYTES));
	assign wr_idx = byte_count[IDX_W-1:0];           // Next free slot

	always_ff @(posedge scan_ready or negedge rst_n)
	begin
		if (!rst_n)
		begin
			message    <= '0;
			byte_count <= '0;
		end
		else if (byte_valid && !full)
		begin
			message[wr_idx] <= byte_data;
			byte_count      <= byte_count + 1'b1;
		end
	end

	// Bytes past the 32nd still complete the handshake upstream,
	// they just never reach the buffer

endmodule

//--- packet_receiver.sv
// ########################################################################
// Incoming link receiver
//   four-phase rdy/ack handshake, one byte latched and
//   reported with a single-cycle valid pulse per transfer
// ########################################################################
`timescale 1ns/1ps

module packet_receiver
	import terminal_pkg::*;
(
	input  logic  scan_ready,
	input  logic  rst_n,
	input  logic  rx_rdy,                            // Partner offers a byte
	input  byte_t rx_data,
	output logic  rx_ack,
	output logic  byte_valid,                        // One pulse per byte
	output byte_t byte_data
);

	recv_state_t state;

	assign rx_ack = (state == RECV_ACK);

	// Data latched as the offer is seen
	always_ff @(posedge scan_ready)
	begin
		if ((state == RECV_WAIT) && rx_rdy)
			byte_data <= rx_data;
	end

	always_ff @(posedge scan_ready or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state      <= RECV_WAIT;
			byte_valid <= 1'b0;
		end
		else
		begin
			byte_valid <= 1'b0;
			case (state)
				RECV_WAIT:
				begin
					if (rx_rdy)
					begin
						state      <= RECV_ACK;      // ack and valid together
						byte_valid <= 1'b1;
					end
				end
				RECV_ACK:
				begin
					if (!rx_rdy)
						state <= RECV_WAIT;          // Partner released, drop ack
				end
				default: state <= RECV_WAIT;
			endcase
		end
	end

endmodule

//--- packet_sender.sv
// ########################################################################
// Outgoing link sender
//   four-phase rdy/ack handshake for one byte per request,
//   followed by a fixed hold-off before the next send
// ########################################################################
`timescale 1ns/1ps

module packet_sender
	import terminal_pkg::*;
(
	input  logic  scan_ready,
	input  logic  rst_n,
	input  logic  send_req,                          // From key decoder
	input  byte_t cur_char,
	output logic  tx_rdy,
	output byte_t tx_data,
	input  logic  tx_ack,
	output logic  send_ready                         // High only when idle
);

	send_state_t       state;
	logic [HOLD_W-1:0] hold_cnt;                     // Cycles spent in hold-off
	logic              accept;

	assign accept     = (state == SEND_IDLE) && send_req;   // Requests drop otherwise
	assign send_ready = (state == SEND_IDLE);
	assign tx_rdy     = (state == SEND_OFFER);

	// Byte captured at the accepted request, stable through the offer
	always_ff @(posedge scan_ready)
	begin
		if (accept)
			tx_data <= cur_char;
	end

	always_ff @(posedge scan_ready or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state    <= SEND_IDLE;
			hold_cnt <= '0;
		end
		else
		begin
			case (state)
				SEND_IDLE:
				begin
					if (accept)
						state <= SEND_OFFER;
				end
				SEND_OFFER:
				begin
					if (tx_ack)
						state <= SEND_RELEASE;       // Drop rdy next cycle
				end
				SEND_RELEASE:
				begin
					if (!tx_ack)
					begin
						state    <= SEND_HOLD;
						hold_cnt <= '0;
					end
				end
				SEND_HOLD:
				begin
					if (hold_cnt == HOLD_W'(SEND_HOLDOFF - 1))
						state <= SEND_IDLE;          // Exactly SEND_HOLDOFF cycles
					else
						hold_cnt <= hold_cnt + 1'b1;
				end
				default: state <= SEND_IDLE;
			endcase
		end
	end

endmodule

//--- key_decoder.sv
// ########################################################################
// Scan-code decoder
//   hex-key make codes to ASCII, space bar counter,
//   Enter send request, break-prefix suppression
// ########################################################################
`timescale 1ns/1ps

module key_decoder
	import terminal_pkg::*;
(
	input  logic   scan_ready,                       // Clock, one edge per domain tick
	input  logic   rst_n,
	input  byte_t  scan_code,
	input  logic   scan_valid,
	output byte_t  cur_char,                         // Last hex character typed
	output space_t space_count,
	output logic   send_req                          // One-cycle pulse on Enter
);

	logic  break_seen;                               // Previous code was SC_BREAK
	logic  hex_hit;
	byte_t hex_char;

	// Hex-key table, anything else is a miss
	always_comb
	begin
		hex_hit  = 1'b1;
		hex_char = 8'h00;
		case (scan_code)
			8'h45: hex_char = "0";
			8'h16: hex_char = "1";
			8'h1E: hex_char = "2";
			8'h26: hex_char = "3";
			8'h25: hex_char = "4";
			8'h2E: hex_char = "5";
			8'h36: hex_char = "6";
			8'h3D: hex_char = "7";
			8'h3E: hex_char = "8";
			8'h46: hex_char = "9";
			8'h1C: hex_char = "A";
			8'h32: hex_char = "B";
			8'h21: hex_char = "C";
			8'h23: hex_char = "D";
			8'h24: hex_char = "E";
			8'h2B: hex_char = "F";
			default: hex_hit = 1'b0;
		endcase
	end

	always_ff @(posedge scan_ready or negedge rst_n)
	begin
		if (!rst_n)
		begin
			cur_char    <= '0;
			space_count <= '0;
			send_req    <= 1'b0;
			break_seen  <= 1'b0;
		end
		else
		begin
			send_req <= 1'b0;                        // Pulse by default
			if (scan_valid)
			begin
				if (scan_code == SC_BREAK)
					break_seen <= 1'b1;
				else if (break_seen)
					break_seen <= 1'b0;              // Release code swallowed
				else
				begin
					if (hex_hit)
						cur_char <= hex_char;
					if (scan_code == SC_ENTER)
						send_req <= 1'b1;
					if (scan_code == SC_SPACE)
						space_count <= space_count + 1'b1;   // Wraps at 1024
				end
			end
		end
	end

endmodule

//--- terminal_pkg.sv
// ########################################################################
// Shared definitions for the keyboard message terminal
//   byte, message, count and space-count types
//   scan-code constants and the send hold-off length
//   sender and receiver FSM state encodings
//   seven-segment pattern function
// ########################################################################

package terminal_pkg;

	typedef logic [7:0] byte_t;                      // Scan codes, characters, link data

	localparam int MSG_BYTES = 32;                   // Bytes in one encrypted message
	localparam int MSG_WORDS = MSG_BYTES / 2;        // 16-bit words shown on the digits
	localparam int IDX_W     = $clog2(MSG_BYTES);    // Buffer write index width

	typedef byte_t [MSG_BYTES-1:0] message_t;        // Byte 0 in the lowest bits
	typedef logic  [5:0]           count_t;          // 0 to 32 bytes held
	typedef logic  [9:0]           space_t;          // Wraps on overflow

	localparam byte_t SC_ENTER = 8'h5A;              // Enter make code
	localparam byte_t SC_SPACE = 8'h29;              // Space bar make code
	localparam byte_t SC_BREAK = 8'hF0;              // Key release prefix

	localparam int SEND_HOLDOFF = 64;                // Cycles between sends
	localparam int HOLD_W       = $clog2(SEND_HOLDOFF);

	typedef enum logic [1:0]
	{
		SEND_IDLE,                                   // Ready for a new request
		SEND_OFFER,                                  // rdy high, waiting for ack
		SEND_RELEASE,                                // rdy low, waiting for ack to drop
		SEND_HOLD                                    // Hold-off count running
	} send_state_t;

	typedef enum logic
	{
		RECV_WAIT,                                   // Waiting for partner rdy
		RECV_ACK                                     // ack high until rdy drops
	} recv_state_t;

	// Active-low segments, bit 0 is segment a and bit 6 is segment g
	function automatic logic [6:0] seg_pattern(input logic [3:0] digit);
		case (digit)
			4'h0: seg_pattern = 7'b1000000;
			4'h1: seg_pattern = 7'b1111001;
			4'h2: seg_pattern = 7'b0100100;
			4'h3: seg_pattern = 7'b0110000;
			4'h4: seg_pattern = 7'b0011001;
			4'h5: seg_pattern = 7'b0010010;
			4'h6: seg_pattern = 7'b0000010;
			4'h7: seg_pattern = 7'b1111000;
			4'h8: seg_pattern = 7'b0000000;
			4'h9: seg_pattern = 7'b0010000;
			4'hA: seg_pattern = 7'b0001000;
			4'hB: seg_pattern = 7'b0000011;          // Lower case b
			4'hC: seg_pattern = 7'b1000110;
			4'hD: seg_pattern = 7'b0100001;          // Lower case d
			4'hE: seg_pattern = 7'b0000110;
			default: seg_pattern = 7'b0001110;       // F
		endcase
	endfunction

endpackage
